//--- verilog/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////////////////////////
    // fetch addressing
    //////////////////////////////////////////////////
    localparam int VA_W     = 32;  // virtual byte address
    localparam int FIP_W    = 28;  // 16-byte line address, va >> 4
    localparam int FIP_STEP = 2;   // one bank covers every other line

    //////////////////////////////////////////////////
    // cache geometry
    //////////////////////////////////////////////////
    localparam int LINE_W   = 128; // one 16-byte line
    localparam int PLINE_W  = 11;  // {pfn[2:0], fip[7:0]}
    localparam int INDEX_W  = 3;   // physical line bits 3..1
    localparam int SETS     = 8;
    localparam int TAG_W    = 7;   // physical line bits 10..4

endpackage

//--- verilog/tlb_pkg.sv
package tlb_pkg;

    //////////////////////////////////////////////////
    // instruction tlb
    //////////////////////////////////////////////////
    localparam int TLB_ENTRIES = 8;   // fully associative

    // virtual page number is fip[27:8], so 4k pages
    localparam int VPN_W       = 20;
    localparam int PFN_W       = 20;

    // only the low frame bits reach the cache
    localparam int PFN_USED_W  = 3;

endpackage

//--- verilog/fip_select.sv
`timescale 1ns/1ps

module fip_select
    import fetch_pkg::*;
#(
    parameter bit ODD_BANK = 1'b0  // 0 even bank, 1 odd bank
) (
    input  logic             clk,
    input  logic             arst_n_i,

    input  logic [VA_W-1:0]  init_addr_i,
    input  logic             is_init_i,
    input  logic             is_resteer_i,
    input  logic             is_br_taken_i,
    input  logic [FIP_W-1:0] wb_fip_i,     // resteer target from writeback
    input  logic [FIP_W-1:0] bp_fip_i,     // branch predictor target

    input  logic             ld_i,         // latch was loaded, advance
    output logic [FIP_W-1:0] fip_o
);

    logic [FIP_W-1:0] init_line;
    logic [FIP_W-1:0] init_fip;
    logic [FIP_W-1:0] fip_q;   // sequential fip
    logic             sel_init;
    logic             sel_wb;
    logic             sel_bp;

    //////////////////////////////////////////////////
    // init split between the two banks
    //////////////////////////////////////////////////
    assign init_line = init_addr_i[VA_W-1 -: FIP_W];

    // keep the line if it already belongs to this bank, else take the next one
    assign init_fip = (init_line[0] == ODD_BANK) ? init_line : init_line + FIP_W'(1);

    //////////////////////////////////////////////////
    // control flow priority
    //////////////////////////////////////////////////
    assign sel_init = is_init_i;
    assign sel_wb   = ~is_init_i & is_resteer_i;
    assign sel_bp   = ~is_init_i & ~is_resteer_i & is_br_taken_i;

    always_comb begin
        if (sel_init) begin
            fip_o = init_fip;
        end else if (sel_wb) begin
            fip_o = wb_fip_i;
        end else if (sel_bp) begin
            fip_o = bp_fip_i;
        end else begin
            fip_o = fip_q;  // no control flow this cycle
        end
    end

    //////////////////////////////////////////////////
    // sequential fip register
    //////////////////////////////////////////////////
    // next line of this bank is two lines ahead
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fip_q <= '0;
        end else if (ld_i) begin
            fip_q <= fip_o + FIP_W'(FIP_STEP);
        end
    end

endmodule

//--- verilog/itlb.sv
`timescale 1ns/1ps

module itlb
    import fetch_pkg::*, tlb_pkg::*;
(
    input  logic [FIP_W-1:0]             fip_i,

    // tlb contents, entry i in slice i
    input  logic [TLB_ENTRIES*VPN_W-1:0] vpn_i,
    input  logic [TLB_ENTRIES*PFN_W-1:0] pfn_i,
    input  logic [TLB_ENTRIES-1:0]       valid_i,
    input  logic [TLB_ENTRIES-1:0]       present_i,
    input  logic [TLB_ENTRIES-1:0]       pcd_i,     // page cache disabled

    output logic [PFN_USED_W-1:0]        pfn_low_o,
    output logic                         hit_o,
    output logic                         tlb_miss_o,
    output logic                         prot_exc_o
);

    logic [VPN_W-1:0]       vpn;
    logic [TLB_ENTRIES-1:0] match;
    logic                   sel_pcd;

    assign vpn = fip_i[FIP_W-1 -: VPN_W];  // fip[27:8]

    //////////////////////////////////////////////////
    // compare against every entry
    //////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = valid_i[i] & present_i[i] & (vpn_i[i*VPN_W +: VPN_W] == vpn);
        end
    end

    // walk down so the lowest matching entry is the last one written
    always_comb begin
        pfn_low_o = '0;
        sel_pcd   = 1'b0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                pfn_low_o = pfn_i[i*PFN_W +: PFN_USED_W];
                sel_pcd   = pcd_i[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // flags
    //////////////////////////////////////////////////
    assign hit_o      = |match;
    assign tlb_miss_o = ~hit_o;

    // fetch never writes, only pcd pages fault
    assign prot_exc_o = hit_o & sel_pcd;

endmodule

//--- verilog/icache_bank.sv
`timescale 1ns/1ps

module icache_bank
    import fetch_pkg::*, tlb_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n_i,

    // lookup
    input  logic [FIP_W-1:0]      fip_i,
    input  logic [PFN_USED_W-1:0] pfn_low_i,
    input  logic                  hit_i,       // tlb hit
    input  logic                  prot_exc_i,

    // line fill
    input  logic                  fill_valid_i,
    input  logic [LINE_W-1:0]     fill_data_i,

    output logic [LINE_W-1:0]     line_o,
    output logic                  miss_o,
    output logic                  write_o,     // line being written, output not valid
    output logic                  fill_req_o,
    output logic [PLINE_W-1:0]    fill_paddr_o
);

    logic [PLINE_W-1:0] paddr;
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic               lookup_hit;
    logic               lookup_miss;
    logic               start_fill;
    logic               fill_done;

    logic [INDEX_W-1:0] fill_index;
    logic [TAG_W-1:0]   fill_tag;

    // set array
    logic [SETS-1:0]    valid_q;
    logic [TAG_W-1:0]   tag_q  [SETS];
    logic [LINE_W-1:0]  data_q [SETS];

    // pending miss
    logic               fill_req_q;
    logic [PLINE_W-1:0] fill_paddr_q;
    logic               write_q;

    //////////////////////////////////////////////////
    // physical line address and lookup
    //////////////////////////////////////////////////
    assign paddr = {pfn_low_i, fip_i[PLINE_W-PFN_USED_W-1:0]};
    assign index = paddr[INDEX_W:1];            // bit 0 picks the bank
    assign tag   = paddr[PLINE_W-1 -: TAG_W];

    assign lookup_hit  = valid_q[index] & (tag_q[index] == tag);
    assign lookup_miss = hit_i & ~prot_exc_i & ~lookup_hit;

    assign line_o = data_q[index];
    assign miss_o = lookup_miss | write_q;

    //////////////////////////////////////////////////
    // single outstanding miss
    //////////////////////////////////////////////////
    // the write cycle still belongs to the last fill, so no new request then
    assign start_fill = lookup_miss & ~fill_req_q & ~write_q;
    assign fill_done  = fill_req_q & fill_valid_i;  // pulse without a request is dropped

    assign fill_index = fill_paddr_q[INDEX_W:1];
    assign fill_tag   = fill_paddr_q[PLINE_W-1 -: TAG_W];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fill_req_q <= 1'b0;
            write_q    <= 1'b0;
        end else begin
            write_q <= fill_done;   // high for one cycle after the fill edge
            if (fill_done) begin
                fill_req_q <= 1'b0;
            end else if (start_fill) begin
                fill_req_q <= 1'b1;
            end
        end
    end

    // address held until the fill arrives
    always_ff @(posedge clk) begin
        if (start_fill) begin
            fill_paddr_q <= paddr;
        end
    end

    //////////////////////////////////////////////////
    // line fill into the array
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (fill_done) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_q[fill_index]  <= fill_tag;
            data_q[fill_index] <= fill_data_i;
        end
    end

    assign write_o      = write_q;
    assign fill_req_o   = fill_req_q;
    assign fill_paddr_o = fill_paddr_q;

endmodule

//--- verilog/fetch_1.sv
`timescale 1ns/1ps

module fetch_1
    import fetch_pkg::*, tlb_pkg::*;
(
    input  logic                         clk,
    input  logic                         arst_n_i,

    // control flow
    input  logic [VA_W-1:0]              init_addr_i,
    input  logic                         is_init_i,
    input  logic [FIP_W-1:0]             wb_fip_even_i,
    input  logic [FIP_W-1:0]             wb_fip_odd_i,
    input  logic                         is_resteer_i,
    input  logic [FIP_W-1:0]             bp_fip_even_i,
    input  logic [FIP_W-1:0]             bp_fip_odd_i,
    input  logic                         is_br_taken_i,

    input  logic                         even_ld_i,   // even latch was loaded
    input  logic                         odd_ld_i,

    // tlb contents, shared by both banks
    input  logic [TLB_ENTRIES*VPN_W-1:0] tlb_vpn_i,
    input  logic [TLB_ENTRIES*PFN_W-1:0] tlb_pfn_i,
    input  logic [TLB_ENTRIES-1:0]       tlb_valid_i,
    input  logic [TLB_ENTRIES-1:0]       tlb_present_i,
    input  logic [TLB_ENTRIES-1:0]       tlb_pcd_i,

    // line fills
    input  logic                         fill_valid_even_i,
    input  logic [LINE_W-1:0]            fill_data_even_i,
    input  logic                         fill_valid_odd_i,
    input  logic [LINE_W-1:0]            fill_data_odd_i,

    output logic [LINE_W-1:0]            line_even_o,
    output logic [LINE_W-1:0]            line_odd_o,
    output logic                         miss_even_o,
    output logic                         miss_odd_o,
    output logic                         write_even_o,
    output logic                         write_odd_o,
    output logic [1:0]                   fip_even_lsb_o,
    output logic [1:0]                   fip_odd_lsb_o,
    output logic                         tlb_miss_even_o,
    output logic                         tlb_miss_odd_o,
    output logic                         prot_exc_even_o,
    output logic                         prot_exc_odd_o,
    output logic                         fill_req_even_o,
    output logic                         fill_req_odd_o,
    output logic [PLINE_W-1:0]           fill_paddr_even_o,
    output logic [PLINE_W-1:0]           fill_paddr_odd_o
);

    logic [FIP_W-1:0]      fip_even;
    logic [FIP_W-1:0]      fip_odd;
    logic [PFN_USED_W-1:0] pfn_low_even;
    logic [PFN_USED_W-1:0] pfn_low_odd;
    logic                  tlb_hit_even;
    logic                  tlb_hit_odd;

    //////////////////////////////////////////////////
    // even bank
    //////////////////////////////////////////////////
    fip_select #(.ODD_BANK(1'b0)) fip_sel_even (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .init_addr_i   (init_addr_i),
        .is_init_i     (is_init_i),
        .is_resteer_i  (is_resteer_i),
        .is_br_taken_i (is_br_taken_i),
        .wb_fip_i      (wb_fip_even_i),
        .bp_fip_i      (bp_fip_even_i),
        .ld_i          (even_ld_i),
        .fip_o         (fip_even)
    );

    itlb itlb_even (
        .fip_i      (fip_even),
        .vpn_i      (tlb_vpn_i),
        .pfn_i      (tlb_pfn_i),
        .valid_i    (tlb_valid_i),
        .present_i  (tlb_present_i),
        .pcd_i      (tlb_pcd_i),
        .pfn_low_o  (pfn_low_even),
        .hit_o      (tlb_hit_even),
        .tlb_miss_o (tlb_miss_even_o),
        .prot_exc_o (prot_exc_even_o)
    );

    icache_bank bank_even (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .fip_i        (fip_even),
        .pfn_low_i    (pfn_low_even),
        .hit_i        (tlb_hit_even),
        .prot_exc_i   (prot_exc_even_o),
        .fill_valid_i (fill_valid_even_i),
        .fill_data_i  (fill_data_even_i),
        .line_o       (line_even_o),
        .miss_o       (miss_even_o),
        .write_o      (write_even_o),
        .fill_req_o   (fill_req_even_o),
        .fill_paddr_o (fill_paddr_even_o)
    );

    //////////////////////////////////////////////////
    // odd bank
    //////////////////////////////////////////////////
    fip_select #(.ODD_BANK(1'b1)) fip_sel_odd (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .init_addr_i   (init_addr_i),
        .is_init_i     (is_init_i),
        .is_resteer_i  (is_resteer_i),
        .is_br_taken_i (is_br_taken_i),
        .wb_fip_i      (wb_fip_odd_i),
        .bp_fip_i      (bp_fip_odd_i),
        .ld_i          (odd_ld_i),
        .fip_o         (fip_odd)
    );

    itlb itlb_odd (
        .fip_i      (fip_odd),
        .vpn_i      (tlb_vpn_i),
        .pfn_i      (tlb_pfn_i),
        .valid_i    (tlb_valid_i),
        .present_i  (tlb_present_i),
        .pcd_i      (tlb_pcd_i),
        .pfn_low_o  (pfn_low_odd),
        .hit_o      (tlb_hit_odd),
        .tlb_miss_o (tlb_miss_odd_o),
        .prot_exc_o (prot_exc_odd_o)
    );

    icache_bank bank_odd (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .fip_i        (fip_odd),
        .pfn_low_i    (pfn_low_odd),
        .hit_i        (tlb_hit_odd),
        .prot_exc_i   (prot_exc_odd_o),
        .fill_valid_i (fill_valid_odd_i),
        .fill_data_i  (fill_data_odd_i),
        .line_o       (line_odd_o),
        .miss_o       (miss_odd_o),
        .write_o      (write_odd_o),
        .fill_req_o   (fill_req_odd_o),
        .fill_paddr_o (fill_paddr_odd_o)
    );

    // low line bits for the decode side
    assign fip_even_lsb_o = fip_even[5:4];
    assign fip_odd_lsb_o  = fip_odd[5:4];

endmodule

//--- tb/fetch_1_tb.sv
`timescale 1ns/1ps

module fetch_1_tb
    import fetch_pkg::*, tlb_pkg::*;
();

    localparam int          RESET_CYCLES    = 8;
    localparam int          N_STEPS         = 200;
    localparam int          FILL_WAIT_MAX   = 16;  // longest a step spends on its fills
    localparam int          WATCHDOG_CYCLES = N_STEPS * FILL_WAIT_MAX + 20;
    localparam logic [15:0] LFSR_SEED       = 16'd59;

    logic                         clk = 1'b0;
    logic                         arst_n_i;
    logic [VA_W-1:0]              init_addr_i;
    logic                         is_init_i, is_resteer_i, is_br_taken_i;
    logic [FIP_W-1:0]             wb_fip_even_i, wb_fip_odd_i;
    logic [FIP_W-1:0]             bp_fip_even_i, bp_fip_odd_i;
    logic                         even_ld_i, odd_ld_i;
    logic [TLB_ENTRIES*VPN_W-1:0] tlb_vpn_i;
    logic [TLB_ENTRIES*PFN_W-1:0] tlb_pfn_i;
    logic [TLB_ENTRIES-1:0]       tlb_valid_i, tlb_present_i, tlb_pcd_i;
    logic                         fill_valid_even_i, fill_valid_odd_i;
    logic [LINE_W-1:0]            fill_data_even_i, fill_data_odd_i;
    logic [LINE_W-1:0]            line_even_o, line_odd_o;
    logic                         miss_even_o, miss_odd_o;
    logic                         write_even_o, write_odd_o;
    logic [1:0]                   fip_even_lsb_o, fip_odd_lsb_o;
    logic                         tlb_miss_even_o, tlb_miss_odd_o;
    logic                         prot_exc_even_o, prot_exc_odd_o;
    logic                         fill_req_even_o, fill_req_odd_o;
    logic [PLINE_W-1:0]           fill_paddr_even_o, fill_paddr_odd_o;

    // reference model indexed by bank with 0 for even and 1 for odd
    logic [FIP_W-1:0]   m_fip_q  [2];
    logic               m_valid  [2][SETS];
    logic [PLINE_W-1:0] m_addr   [2][SETS];   // whole physical line held in each set
    logic [LINE_W-1:0]  m_data   [2][SETS];
    logic               m_req    [2];
    logic [PLINE_W-1:0] m_paddr  [2];
    logic               m_write  [2];
    int                 wait_cnt [2];         // cycles until the fill pulse
    logic [15:0]        lfsr;

    fetch_1 dut0 (.*);

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // random numbers
    //////////////////////////////////////////////////
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [LINE_W-1:0] take_bits(input int n);
        logic [LINE_W-1:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[LINE_W-2:0], lfsr[0]};
        end
        return r;
    endfunction

    // random line in pages 0x100..0x107
    // stepping past offset 0xff runs into the unmapped page 0x108
    function automatic logic [FIP_W-1:0] rand_line();
        logic [2:0] pg;
        logic [7:0] off;
        pg  = 3'(take_bits(3));
        off = 8'(take_bits(8));
        return {17'h00020, pg, off};
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic report_mismatch(input string name, input string exp_s, input string act_s);
        $display("error at time %0t: %s expected %s, got %s", $time, name, exp_s, act_s);
        $display(">>> FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_line(input string name, input logic [LINE_W-1:0] exp_v,
                              input logic [LINE_W-1:0] act_v);
        if (act_v !== exp_v)
            report_mismatch(name, $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic check_paddr(input string name, input logic [PLINE_W-1:0] exp_v,
                               input logic [PLINE_W-1:0] act_v);
        if (act_v !== exp_v)
            report_mismatch(name, $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic check_lsb(input string name, input logic [1:0] exp_v,
                             input logic [1:0] act_v);
        if (act_v !== exp_v)
            report_mismatch(name, $sformatf("%b", exp_v), $sformatf("%b", act_v));
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v)
            report_mismatch(name, $sformatf("%b", exp_v), $sformatf("%b", act_v));
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    task automatic load_tlb();
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            tlb_vpn_i[i*VPN_W +: VPN_W] = 20'h00100 + VPN_W'(i);
            tlb_pfn_i[i*PFN_W +: PFN_W] = 20'h0a5a0 | PFN_W'((i * 5 + 3) % 8);
        end
        tlb_valid_i   = 8'hff;
        tlb_present_i = 8'h7f;  // page 0x107 not present
        tlb_pcd_i     = 8'h24;  // pages 0x102 and 0x105 cache disabled
    endtask

    // first valid and present entry with the page wins
    task automatic translate(input logic [FIP_W-1:0] fip, output logic hit,
                             output logic [PFN_USED_W-1:0] pfn_low, output logic pcd);
        hit     = 1'b0;
        pfn_low = '0;
        pcd     = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!hit && tlb_valid_i[i] && tlb_present_i[i]
                    && tlb_vpn_i[i*VPN_W +: VPN_W] == fip[FIP_W-1:8]) begin
                hit     = 1'b1;
                pfn_low = tlb_pfn_i[i*PFN_W +: PFN_USED_W];
                pcd     = tlb_pcd_i[i];
            end
        end
    endtask

    function automatic logic [FIP_W-1:0] model_fip(input int b);
        logic [FIP_W-1:0] line;
        line = init_addr_i[VA_W-1:4];
        if (is_init_i)
            return (int'(line[0]) == b) ? line : line + FIP_W'(1);
        if (is_resteer_i)
            return (b == 1) ? wb_fip_odd_i : wb_fip_even_i;
        if (is_br_taken_i)
            return (b == 1) ? bp_fip_odd_i : bp_fip_even_i;
        return m_fip_q[b];
    endfunction

    task automatic lookup(input int b, output logic [FIP_W-1:0] fip, output logic hit,
                          output logic pcd, output logic [PLINE_W-1:0] paddr,
                          output logic lmiss);
        logic [PFN_USED_W-1:0] pfn_low;
        logic [INDEX_W-1:0]    idx;
        fip = model_fip(b);
        translate(fip, hit, pfn_low, pcd);
        paddr = {pfn_low, fip[7:0]};
        idx   = paddr[INDEX_W:1];
        lmiss = hit && !pcd && !(m_valid[b][idx] && m_addr[b][idx] == paddr);
    endtask

    task automatic model_reset();
        for (int b = 0; b < 2; b++) begin
            m_fip_q[b]  = '0;
            m_req[b]    = 1'b0;
            m_write[b]  = 1'b0;
            wait_cnt[b] = 0;
            for (int s = 0; s < SETS; s++)
                m_valid[b][s] = 1'b0;
        end
    endtask

    // state after the coming edge from the inputs held now
    task automatic advance_model();
        logic [FIP_W-1:0]   fip;
        logic               hit;
        logic               pcd;
        logic               lmiss;
        logic [PLINE_W-1:0] paddr;
        for (int b = 0; b < 2; b++) begin
            lookup(b, fip, hit, pcd, paddr, lmiss);
            if ((b == 1) ? odd_ld_i : even_ld_i)
                m_fip_q[b] = fip + FIP_W'(FIP_STEP);
            if (m_req[b] && ((b == 1) ? fill_valid_odd_i : fill_valid_even_i)) begin
                m_valid[b][m_paddr[b][INDEX_W:1]] = 1'b1;
                m_addr[b][m_paddr[b][INDEX_W:1]]  = m_paddr[b];
                m_data[b][m_paddr[b][INDEX_W:1]]  = (b == 1) ? fill_data_odd_i : fill_data_even_i;
                m_req[b]   = 1'b0;
                m_write[b] = 1'b1;
            end else begin
                if (lmiss && !m_req[b] && !m_write[b]) begin
                    m_req[b]    = 1'b1;
                    m_paddr[b]  = paddr;
                    wait_cnt[b] = int'(take_bits(2));
                end
                m_write[b] = 1'b0;
            end
        end
    endtask

    task automatic check_bank(input int b, input logic [LINE_W-1:0] act_line,
                              input logic act_miss, input logic act_write, input logic act_req,
                              input logic [PLINE_W-1:0] act_paddr, input logic [1:0] act_lsb,
                              input logic act_tmiss, input logic act_prot);
        string              s;
        logic [FIP_W-1:0]   fip;
        logic               hit;
        logic               pcd;
        logic               lmiss;
        logic               exp_miss;
        logic [PLINE_W-1:0] paddr;
        s = (b == 1) ? "odd" : "even";
        lookup(b, fip, hit, pcd, paddr, lmiss);
        exp_miss = lmiss | m_write[b];
        check_lsb($sformatf("fip_%s_lsb_o", s), fip[5:4], act_lsb);
        check_bit($sformatf("tlb_miss_%s_o", s), !hit, act_tmiss);
        check_bit($sformatf("prot_exc_%s_o", s), hit & pcd, act_prot);
        check_bit($sformatf("miss_%s_o", s), exp_miss, act_miss);
        check_bit($sformatf("write_%s_o", s), m_write[b], act_write);
        check_bit($sformatf("fill_req_%s_o", s), m_req[b], act_req);
        if (m_req[b])
            check_paddr($sformatf("fill_paddr_%s_o", s), m_paddr[b], act_paddr);
        if (!exp_miss && hit && !pcd)
            check_line($sformatf("line_%s_o", s), m_data[b][paddr[INDEX_W:1]], act_line);
    endtask

    task automatic check_outputs();
        check_bank(0, line_even_o, miss_even_o, write_even_o, fill_req_even_o,
                   fill_paddr_even_o, fip_even_lsb_o, tlb_miss_even_o, prot_exc_even_o);
        check_bank(1, line_odd_o, miss_odd_o, write_odd_o, fill_req_odd_o,
                   fill_paddr_odd_o, fip_odd_lsb_o, tlb_miss_odd_o, prot_exc_odd_o);
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    // op 0 to 3 is init, resteer, branch or ld only
    // lower priority sources are set at random alongside
    task automatic drive_event(input int step);
        logic [1:0]      op;
        logic [VA_W-1:0] addr;
        logic            lo_a;
        logic            lo_b;
        op   = (step == 0) ? 2'd0 : 2'(take_bits(2));
        addr = {rand_line(), 4'(take_bits(4))};
        if (step == 0)
            addr[VA_W-1:12] = 20'h00100;  // first init lands on a plain mapped page
        lo_a = 1'(take_bits(1));
        lo_b = 1'(take_bits(1));
        init_addr_i   <= addr;
        wb_fip_even_i <= rand_line() & ~FIP_W'(1);
        wb_fip_odd_i  <= rand_line() | FIP_W'(1);
        bp_fip_even_i <= rand_line() & ~FIP_W'(1);
        bp_fip_odd_i  <= rand_line() | FIP_W'(1);
        is_init_i     <= (op == 2'd0);
        is_resteer_i  <= (op == 2'd1) | ((op == 2'd0) & lo_a);
        is_br_taken_i <= (op == 2'd2) | ((op < 2'd2) & lo_b);
        even_ld_i     <= (op != 2'd3) | 1'(take_bits(1));
        odd_ld_i      <= (op != 2'd3) | 1'(take_bits(1));
    endtask

    task automatic drive_idle();
        is_init_i     <= 1'b0;
        is_resteer_i  <= 1'b0;
        is_br_taken_i <= 1'b0;
        even_ld_i     <= 1'b0;
        odd_ld_i      <= 1'b0;
    endtask

    task automatic drive_fills();
        logic              pulse;
        logic [LINE_W-1:0] data;
        for (int b = 0; b < 2; b++) begin
            data = take_bits(LINE_W);
            if (m_req[b]) begin
                pulse = (wait_cnt[b] == 0);
                if (!pulse)
                    wait_cnt[b]--;
            end else begin
                pulse = (3'(take_bits(3)) == 3'd0);  // stray pulse that the bank ignores
            end
            if (b == 0) begin
                fill_valid_even_i <= pulse;
                fill_data_even_i  <= data;
            end else begin
                fill_valid_odd_i <= pulse;
                fill_data_odd_i  <= data;
            end
        end
    endtask

    task automatic run_cycle(input logic event_cycle, input int step);
        @(posedge clk);
        if (event_cycle)
            drive_event(step);
        else
            drive_idle();
        drive_fills();
        @(negedge clk);     // combinational outputs settled
        check_outputs();
        advance_model();
    endtask

    function automatic logic banks_busy();
        return fill_req_even_o | fill_req_odd_o | write_even_o | write_odd_o
             | miss_even_o | miss_odd_o;
    endfunction

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////
    initial begin : stimulus
        lfsr              = LFSR_SEED;
        arst_n_i          = 1'b0;
        init_addr_i       = '0;
        is_init_i         = 1'b0;
        is_resteer_i      = 1'b0;
        is_br_taken_i     = 1'b0;
        wb_fip_even_i     = '0;
        wb_fip_odd_i      = '0;
        bp_fip_even_i     = '0;
        bp_fip_odd_i      = '0;
        even_ld_i         = 1'b0;
        odd_ld_i          = 1'b0;
        fill_valid_even_i = 1'b0;
        fill_valid_odd_i  = 1'b0;
        fill_data_even_i  = '0;
        fill_data_odd_i   = '0;
        load_tlb();
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        check_outputs();    // nothing pending out of reset
        advance_model();
        for (int step = 0; step < N_STEPS; step++) begin
            run_cycle(1'b1, step);
            while (banks_busy())
                run_cycle(1'b0, step);  // wait for the fills of this step
        end
        $display(">>> PASS");
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run hung, fills did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- fetch_1.f
verilog/fetch_pkg.sv
verilog/tlb_pkg.sv
verilog/fip_select.sv
verilog/itlb.sv
verilog/icache_bank.sv
verilog/fetch_1.sv
tb/fetch_1_tb.sv
